// ==== tof_defs.svh ====
`ifndef TOF_DEFS_SVH
`define TOF_DEFS_SVH

// histogram geometry

// bits of one bin index, 16 bins per histogram
`define NB 4

// timestamp holds a coarse field over a fine field
`define TS_W (2 * `NB)

// bits of one bin count
`define PEAK_W 8

// pixels visited round-robin
`define PIXEL_NUM 2

// events per pixel on each visit
`define DATA_NUM 3

// full pixel sweeps per pass
`define ACQ_NUM 2

// one histogram per pixel in the shared bin memory
`define BIN_NUM (`PIXEL_NUM * (1 << `NB))

`endif

// ==== tof_pkg.sv ====
`include "tof_defs.svh"

package tof_pkg;

    // coarse decode, upper field picks the bin
    typedef struct packed {
        logic [`NB-1:0]        coarse_bin;
        logic [`TS_W-`NB-1:0]  residue;
    } ts_coarse_t;

    // fine decode, upper field must match the coarse peak
    typedef struct packed {
        logic [`NB-1:0]        window_tag;
        logic [`TS_W-`NB-1:0]  fine_bin;
    } ts_fine_t;

    // one timestamp, read through either view depending on the pass
    typedef union packed {
        ts_coarse_t coarse;
        ts_fine_t   fine;
    } ts_word_u;

    // event handed from bin_select to his_builder
    typedef struct packed {
        logic           valid;
        logic [`NB-1:0] pixel;
        logic [`NB-1:0] bin;
        logic           last;
    } hist_event_t;

    // peak of one histogram at pass end
    typedef struct packed {
        logic [`NB-1:0]     bin;
        logic [`PEAK_W-1:0] count;
    } pixel_peak_t;

    // frame result of one pixel
    typedef struct packed {
        logic [`NB-1:0]     ch_bin;
        logic [`NB-1:0]     fh_bin;
        logic [`PEAK_W-1:0] fh_count;
    } peak_result_t;

endpackage

// ==== event_sequencer.sv ====
`include "tof_defs.svh"

module event_sequencer (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           ts_valid,
    output logic [`NB-1:0] pixel,
    output logic           his_num,
    output logic           pass_last
);

    localparam int IN_W  = $clog2(`DATA_NUM);
    localparam int ACQ_W = $clog2(`ACQ_NUM);

    // terminal values of the three counters
    localparam logic [IN_W-1:0]  IN_LAST  = IN_W'(`DATA_NUM - 1);
    localparam logic [`NB-1:0]   PIX_LAST = `NB'(`PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(`ACQ_NUM - 1);

    logic [IN_W-1:0]  in_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             in_wrap;
    logic             pix_wrap;
    logic             acq_wrap;

    always_comb begin
        in_wrap  = (in_cnt == IN_LAST);
        pix_wrap = (pixel == PIX_LAST);
        acq_wrap = (acq_cnt == ACQ_LAST);
    end

    // strobe that closes the pass, all counters at their limit
    assign pass_last = ts_valid && in_wrap && pix_wrap && acq_wrap;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            in_cnt  <= '0;
            pixel   <= '0;
            acq_cnt <= '0;
            his_num <= 1'b0;
        end else if (ts_valid) begin
            // events within one pixel visit
            if (in_wrap) begin
                in_cnt <= '0;
                // next pixel once its events are in
                if (pix_wrap) begin
                    pixel <= '0;
                    // one sweep over all pixels done
                    if (acq_wrap) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                in_cnt <= in_cnt + 1'b1;
            end
            // coarse to fine and back, visible the cycle after
            if (pass_last) begin
                his_num <= ~his_num;
            end
        end
    end

endmodule

// ==== bin_select.sv ====
`include "tof_defs.svh"

module bin_select import tof_pkg::*; (
    input  logic           ts_valid,
    input  ts_word_u       ts_word,
    input  logic           his_num,
    input  logic [`NB-1:0] pixel,
    input  logic           pass_last,
    input  logic [`NB-1:0] ch_peak,
    output hist_event_t    ev
);

    logic in_window;

    always_comb begin
        // fine window is the coarse peak bin of this pixel
        in_window = (ts_word.fine.window_tag == ch_peak);

        ev.pixel = pixel;
        // last marker rides on every strobe, gated or not
        ev.last  = pass_last;

        if (his_num) begin
            // fine pass, lower field is the bin
            ev.bin   = ts_word.fine.fine_bin;
            // outside the window the slot is used but nothing counts
            ev.valid = ts_valid && in_window;
        end else begin
            // coarse pass, upper field is the bin
            ev.bin   = ts_word.coarse.coarse_bin;
            ev.valid = ts_valid;
        end
    end

endmodule

// ==== his_builder.sv ====
`include "tof_defs.svh"

module his_builder import tof_pkg::*; (
    input  logic                          clk,
    input  logic                          combin_res,
    input  hist_event_t                   ev,
    output logic                          pass_done,
    output pixel_peak_t [`PIXEL_NUM-1:0]  peaks
);

    localparam int ADDR_W = $clog2(`BIN_NUM);
    localparam int PIX_W  = $clog2(`PIXEL_NUM);

    localparam logic [`PEAK_W-1:0] CNT_ONE = 1;

    // bin counts, one histogram per pixel
    logic [`PEAK_W-1:0] bin_mem [`BIN_NUM];
    // set on first hit, cleared in bulk at pass end
    logic [`BIN_NUM-1:0] bin_vld;

    logic [ADDR_W-1:0]  addr;
    logic [`PEAK_W-1:0] new_cnt;

    // compare stage
    logic               s1_vld;
    logic               s1_last;
    logic [`PEAK_W-1:0] s1_cnt;
    logic [`NB-1:0]     s1_bin;
    logic [PIX_W-1:0]   s1_pix;

    // running maximum and its bin per pixel
    pixel_peak_t [`PIXEL_NUM-1:0] max_q;

    // pixel selects the histogram, bin the entry within it
    assign addr = ADDR_W'({ev.pixel, ev.bin});

    always_comb begin
        // stale count from an earlier pass reads as empty
        if (bin_vld[addr]) begin
            new_cnt = bin_mem[addr] + 1'b1;
        end else begin
            new_cnt = CNT_ONE;
        end
    end

    // read-modify-write in the strobe cycle
    always_ff @(posedge clk) begin
        if (ev.valid) begin
            bin_mem[addr] <= new_cnt;
        end
        s1_cnt <= new_cnt;
        s1_bin <= ev.bin;
        s1_pix <= PIX_W'(ev.pixel);
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_vld   <= '0;
            max_q     <= '0;
            s1_vld    <= 1'b0;
            s1_last   <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            if (pass_done) begin
                // lazy clear, every histogram starts empty next pass
                bin_vld <= '0;
                max_q   <= '0;
            end else begin
                if (ev.valid) begin
                    bin_vld[addr] <= 1'b1;
                end
                // strictly greater, so ties keep the earlier bin
                if (s1_vld && (s1_cnt > max_q[s1_pix].count)) begin
                    max_q[s1_pix].bin   <= s1_bin;
                    max_q[s1_pix].count <= s1_cnt;
                end
            end
            s1_vld    <= ev.valid;
            s1_last   <= ev.last;
            // two cycles after the last strobe, maxima are final
            pass_done <= s1_last;
        end
    end

    // peaks are sampled while pass_done is high
    assign peaks = max_q;

endmodule

// ==== peak_store.sv ====
`include "tof_defs.svh"

module peak_store import tof_pkg::*; (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          pass_done,
    input  logic                          his_num,
    input  pixel_peak_t [`PIXEL_NUM-1:0]  peaks,
    input  logic [`NB-1:0]                pixel,
    input  logic [`NB-1:0]                rd_pixel,
    output logic [`NB-1:0]                ch_peak,
    output logic                          peak_done,
    output peak_result_t                  peak_rd
);

    localparam int PIX_W = $clog2(`PIXEL_NUM);

    // per-pixel frame results
    peak_result_t [`PIXEL_NUM-1:0] res_q;

    // his_num has already toggled when pass_done arrives,
    // high here means the coarse pass just ended
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            res_q     <= '0;
            peak_done <= 1'b0;
        end else begin
            if (pass_done) begin
                for (int i = 0; i < `PIXEL_NUM; i++) begin
                    if (his_num) begin
                        res_q[i].ch_bin <= peaks[i].bin;
                    end else begin
                        res_q[i].fh_bin   <= peaks[i].bin;
                        res_q[i].fh_count <= peaks[i].count;
                    end
                end
            end
            // frame complete once the fine peaks are in
            peak_done <= pass_done && !his_num;
        end
    end

    // window for the fine pass of the pixel now served
    assign ch_peak = res_q[PIX_W'(pixel)].ch_bin;

    // readout by pixel index
    assign peak_rd = res_q[PIX_W'(rd_pixel)];

endmodule

// ==== tof_histogram_top.sv ====
`include "tof_defs.svh"

module tof_histogram_top import tof_pkg::*; (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           ts_valid,
    input  ts_word_u       ts_word,
    input  logic [`NB-1:0] rd_pixel,
    output logic           his_num,
    output logic           peak_done,
    output peak_result_t   peak_rd
);

    logic [`NB-1:0]               pixel;
    logic                         pass_last;
    hist_event_t                  ev;
    logic                         pass_done;
    pixel_peak_t [`PIXEL_NUM-1:0] peaks;
    logic [`NB-1:0]               ch_peak;

    // event, pixel and acquisition counting
    event_sequencer u_seq (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .pixel      (pixel),
        .his_num    (his_num),
        .pass_last  (pass_last)
    );

    // timestamp decode and fine window gate
    bin_select u_sel (
        .ts_valid  (ts_valid),
        .ts_word   (ts_word),
        .his_num   (his_num),
        .pixel     (pixel),
        .pass_last (pass_last),
        .ch_peak   (ch_peak),
        .ev        (ev)
    );

    // bin counts and running peaks
    his_builder u_his (
        .clk        (clk),
        .combin_res (combin_res),
        .ev         (ev),
        .pass_done  (pass_done),
        .peaks      (peaks)
    );

    // coarse and fine results, readout
    peak_store u_store (
        .clk        (clk),
        .combin_res (combin_res),
        .pass_done  (pass_done),
        .his_num    (his_num),
        .peaks      (peaks),
        .pixel      (pixel),
        .rd_pixel   (rd_pixel),
        .ch_peak    (ch_peak),
        .peak_done  (peak_done),
        .peak_rd    (peak_rd)
    );

endmodule

// ==== tof_histogram_assert.sv ====
module tof_histogram_assert (
    input logic clk,
    input logic combin_res,
    input logic ts_valid,
    input logic pass_last,
    input logic his_num,
    input logic peak_done
);

    timeunit 1ns;
    timeprecision 100ps;

    // source stays quiet while a finished pass drains
    a_gap_after_last: assert property (
        @(posedge clk) disable iff (!combin_res)
        ts_valid |-> !($past(pass_last, 1) || $past(pass_last, 2) || $past(pass_last, 3))
    ) else $error("ts_valid within three cycles of the last strobe of a pass");

    // frame complete is a single pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!combin_res)
        $past(peak_done) |-> !peak_done
    ) else $error("peak_done held high for more than one cycle");

    // pass flag moves only right after a last strobe
    a_pass_toggle: assert property (
        @(posedge clk) disable iff (!combin_res)
        (his_num != $past(his_num)) |-> $past(pass_last)
    ) else $error("his_num changed without a preceding last strobe");

endmodule

bind tof_histogram_top tof_histogram_assert u_assert (
    .clk        (clk),
    .combin_res (combin_res),
    .ts_valid   (ts_valid),
    .pass_last  (pass_last),
    .his_num    (his_num),
    .peak_done  (peak_done)
);

// ==== tof_histogram_tb.sv ====
`include "tof_defs.svh"

module tof_histogram_tb import tof_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TS_BITS   = `TS_W;
    localparam int NB_BITS   = `NB;
    localparam int PASS_EV   = `DATA_NUM * `PIXEL_NUM * `ACQ_NUM;
    // per frame two passes of timestamps then one result per pixel
    localparam int FRAME_LEN = 2 * PASS_EV + `PIXEL_NUM;
    localparam int FRAMES    = 2;
    localparam int PAT_WORDS = FRAMES * FRAME_LEN;
    // two frames of about 45 cycles each plus reset fit well inside this limit
    localparam int TIMEOUT_CYCLES = 400;
    localparam int DONE_LATENCY   = 3;
    localparam int DONE_WAIT      = 10;

    logic           clk;
    logic           combin_res;
    logic           ts_valid;
    ts_word_u       ts_word;
    logic [`NB-1:0] rd_pixel;
    logic           his_num;
    logic           peak_done;
    peak_result_t   peak_rd;

    logic [$bits(peak_result_t)-1:0] pat_mem [PAT_WORDS];

    int errors;
    int checks;
    int frame_ev;
    int cycles;

    tof_histogram_top UUT (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .ts_word    (ts_word),
        .rd_pixel   (rd_pixel),
        .his_num    (his_num),
        .peak_done  (peak_done),
        .peak_rd    (peak_rd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

    // fine pass runs from event PASS_EV up to the end of the frame
    function automatic logic expected_his_num(input int n);
        return (n >= PASS_EV) && (n < 2 * PASS_EV);
    endfunction

    // one falling edge where outputs have settled since the rising edge
    task automatic drive_cycle(input logic valid, input logic [TS_BITS-1:0] word);
        logic exp_hn;
        @(negedge clk);
        exp_hn = expected_his_num(frame_ev);
        checks++;
        if (his_num !== exp_hn) begin
            errors++;
            $display("Fail his_num after event %0d: got %h expected %h",
                     frame_ev, his_num, exp_hn);
        end
        ts_valid = valid;
        ts_word  = word;
        if (valid) begin
            frame_ev++;
        end
    endtask

    // quiet cycles in which no frame may complete
    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, TS_BITS'($urandom()));
            checks++;
            if (peak_done !== 1'b0) begin
                errors++;
                $display("Fail peak_done while idle: got %h expected %h", peak_done, 1'b0);
            end
        end
    endtask

    task automatic send_pass(input int base);
        for (int i = 0; i < PASS_EV; i++) begin
            drive_cycle(1'b1, pat_mem[base + i][TS_BITS-1:0]);
        end
    endtask

    // count falling edges from the last strobe to peak_done
    task automatic wait_peak_done();
        int lat;
        lat = 0;
        do begin
            drive_cycle(1'b0, TS_BITS'($urandom()));
            lat++;
        end while (!peak_done && lat < DONE_WAIT);
        checks++;
        if (!peak_done) begin
            errors++;
            $display("peak_done never rose within %0d cycles of the last event", DONE_WAIT);
        end else if (lat != DONE_LATENCY) begin
            errors++;
            $display("Fail peak_done latency: got %h expected %h", lat, DONE_LATENCY);
        end
    endtask

    task automatic check_pixel(input int p, input peak_result_t exp_res);
        checks += 3;
        if (peak_rd.ch_bin !== exp_res.ch_bin) begin
            errors++;
            $display("Fail peak_rd.ch_bin pixel %0d: got %h expected %h",
                     p, peak_rd.ch_bin, exp_res.ch_bin);
        end
        if (peak_rd.fh_bin !== exp_res.fh_bin) begin
            errors++;
            $display("Fail peak_rd.fh_bin pixel %0d: got %h expected %h",
                     p, peak_rd.fh_bin, exp_res.fh_bin);
        end
        if (peak_rd.fh_count !== exp_res.fh_count) begin
            errors++;
            $display("Fail peak_rd.fh_count pixel %0d: got %h expected %h",
                     p, peak_rd.fh_count, exp_res.fh_count);
        end
    endtask

    // rd_pixel set on one falling edge and peak_rd read on the next
    task automatic read_results(input int base);
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            rd_pixel = NB_BITS'(p);
            idle_cycles(1);
            check_pixel(p, pat_mem[base + 2 * PASS_EV + p]);
        end
    endtask

    task automatic check_reset_state();
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            rd_pixel = NB_BITS'(p);
            @(negedge clk);
            checks += 3;
            if (his_num !== 1'b0) begin
                errors++;
                $display("Fail his_num after reset: got %h expected %h", his_num, 1'b0);
            end
            if (peak_done !== 1'b0) begin
                errors++;
                $display("Fail peak_done after reset: got %h expected %h", peak_done, 1'b0);
            end
            if (peak_rd !== '0) begin
                errors++;
                $display("Fail peak_rd pixel %0d after reset: got %h expected %h",
                         p, peak_rd, 16'h0);
            end
        end
    endtask

    task automatic run_frame(input int f);
        int base;
        base = f * FRAME_LEN;
        frame_ev = 0;
        send_pass(base);
        // gap lets the coarse peaks settle into the window
        idle_cycles(3 + ($urandom() % 4));
        send_pass(base + PASS_EV);
        wait_peak_done();
        read_results(base);
        idle_cycles(3 + ($urandom() % 4));
    endtask

    initial begin
        void'($urandom(32'hcb25));
        errors     = 0;
        checks     = 0;
        frame_ev   = 0;
        combin_res = 1'b0;
        ts_valid   = 1'b0;
        ts_word    = '0;
        rd_pixel   = '0;
        // unread words keep a fill that no timestamp or result word can take
        for (int i = 0; i < PAT_WORDS; i++) begin
            pat_mem[i] = {4'hf, 12'(i)};
        end
        $readmemh("tof_patterns.hex", pat_mem);
        if (pat_mem[PAT_WORDS-1] === {4'hf, 12'(PAT_WORDS - 1)}) begin
            errors++;
            $display("pattern file is missing or shorter than %0d words", PAT_WORDS);
        end
        repeat (5) @(negedge clk);
        combin_res = 1'b1;
        check_reset_state();
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tof_patterns.hex ====
// per frame: 12 coarse timestamps, 12 fine timestamps, in event order
// then one result word per pixel, {ch_bin, fh_bin, fh_count}
// frame 0
3a
51
5c
c2
c8
1f
37
94
2e
c0
46
1b
5a
53
5a
0c
2c
3c
7a
5a
53
1c
bc
dc
5a03
c000
// frame 1
82
8f
13
61
c4
69
10
1d
a5
2a
6e
27
14
13
14
6b
6b
65
3a
13
14
6b
6b
65
1403
6b04

// ==== vlog.f ====
+incdir+.
tof_pkg.sv
event_sequencer.sv
bin_select.sv
his_builder.sv
peak_store.sv
tof_histogram_top.sv
tof_histogram_assert.sv
tof_histogram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the histogram testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tof_histogram_tb \
    -f vlog.f -o tof_sim &&
./obj_dir/tof_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "^Done: no errors$" sim.log 2>/dev/null && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
